/* list.f */
+incdir+rtl
rtl/lsu_types_pkg.sv
rtl/stbuf_pkg.sv
rtl/stbuf_entry_if.sv
rtl/stbuf_alloc.sv
rtl/stbuf_array.sv
rtl/stbuf_fwd.sv
rtl/stbuf_top.sv
testbench/stbuf_checker.sv
testbench/stbuf_monitor.sv
testbench/tb_stbuf.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the store buffer testbench with Verilator, run it, then search the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_stbuf -f list.f -o sim_tb \
   > build.log 2>&1 \
   && ./obj_dir/sim_tb +verilator+error+limit+100 > sim.log 2>&1 \
   || echo "build or simulation returned an error, see build.log and sim.log"
grep -q "Done: no errors" sim.log && echo "PASS" && exit 0 || { echo "FAIL"; exit 1; }

/* testbench/tb_stbuf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stbuf
   import lsu_types_pkg::*;
();

   localparam int test_cycles   = 55;  // reset plus all six tests
   localparam int timeout_limit = 2 * test_cycles + 100;

   logic         clk;
   logic         arst_n;
   logic         st_vld;
   lsu_addr_t    st_addr;
   access_size_e st_size;
   lsu_data_t    st_data;
   logic         stbuf_commit;
   logic         ld_cmpen;
   lsu_addr_t    ld_addr;
   logic         stbuf_reqvld;
   word_addr_t   stbuf_addr;
   lsu_data_t    stbuf_data;
   byte_en_t     fwd_byteen;
   lsu_data_t    fwd_data;
   logic         stbuf_empty;
   logic         stbuf_full;
   int           cycle_cnt = 0;

   stbuf_top dut (.*);

   stbuf_monitor mon (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // --------------------
   // stimulus helpers
   // --------------------
   task automatic drive(logic st, lsu_addr_t sa, access_size_e sz, lsu_data_t sd,
                        logic cm, logic ld, lsu_addr_t la);
      @(negedge clk);
      st_vld       = st;
      st_addr      = sa;
      st_size      = sz;
      st_data      = sd;
      stbuf_commit = cm;
      ld_cmpen     = ld;
      ld_addr      = la;
   endtask

   task automatic put_store(lsu_addr_t a, access_size_e sz);
      drive(1'b1, a, sz, $urandom(), 1'b0, 1'b0, '0);
   endtask

   task automatic pop_head();
      drive(1'b0, '0, size_word, '0, 1'b1, 1'b0, '0);
   endtask

   task automatic load_compare(lsu_addr_t a);
      drive(1'b0, '0, size_word, '0, 1'b0, 1'b1, a);
   endtask

   task automatic idle(int n);
      repeat (n) drive(1'b0, '0, size_word, '0, 1'b0, 1'b0, '0);
   endtask

   // report a test after its last falling-edge compare
   task automatic close_test();
      @(posedge clk);
      mon.end_test();
   endtask

   // --------------------
   // test sequence
   // --------------------
   initial begin
      void'($urandom(48408));
      arst_n = 1'b0;
      st_vld = 1'b0;
      st_addr = '0;
      st_size = size_word;
      st_data = '0;
      stbuf_commit = 1'b0;
      ld_cmpen = 1'b0;
      ld_addr = '0;
      mon.begin_test("reset_values");
      repeat (10) @(negedge clk);
      arst_n = 1'b1;

      idle(2);
      close_test();

      mon.begin_test("order_and_full");
      put_store(16'h0100, size_word);
      put_store(16'h0204, size_word);
      put_store(16'h0308, size_word);
      put_store(16'h040c, size_word);
      idle(1);
      repeat (4) pop_head();  // head must follow store order
      idle(1);
      close_test();

      mon.begin_test("coalescing");
      put_store(16'h0501, size_byte);
      put_store(16'h0502, size_half);  // same word, merges
      load_compare(16'h0500);          // merged enables show on the forward path
      pop_head();
      idle(1);
      close_test();

      mon.begin_test("forwarding");
      put_store(16'h0600, size_word);
      load_compare(16'h0602);
      idle(1);
      load_compare(16'h0700);  // absent word
      idle(1);
      pop_head();
      idle(1);
      close_test();

      mon.begin_test("fill_and_drain");
      put_store(16'h0a00, size_word);
      put_store(16'h0b04, size_word);
      put_store(16'h0c08, size_word);
      put_store(16'h0d0c, size_word);
      idle(1);
      repeat (4) begin
         pop_head();
         idle(1);
      end
      close_test();

      mon.begin_test("store_during_pop");
      put_store(16'h0e00, size_byte);
      idle(1);
      drive(1'b1, 16'h0e02, size_half, $urandom(), 1'b1, 1'b0, '0);  // same word as the head
      idle(1);
      load_compare(16'h0e00);
      idle(1);
      pop_head();
      idle(1);
      close_test();

      mon.report_counts(dut.chk.fails);
      if (mon.errors == 0 && dut.chk.fails == 0) begin
         $display("Done: no errors");
      end else begin
         $display("Done: errors found");
      end
      $finish;
   end

   // run limit
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_limit) begin
         $display("run did not finish within %0d cycles", timeout_limit);
         $display("Done: errors found");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* testbench/stbuf_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stbuf_defines.svh"

module stbuf_monitor
   import lsu_types_pkg::*;
(
   input logic         clk,
   input logic         arst_n,
   input logic         st_vld,
   input lsu_addr_t    st_addr,
   input access_size_e st_size,
   input lsu_data_t    st_data,
   input logic         stbuf_commit,
   input logic         ld_cmpen,
   input lsu_addr_t    ld_addr,
   input logic         stbuf_reqvld,
   input word_addr_t   stbuf_addr,
   input lsu_data_t    stbuf_data,
   input byte_en_t     fwd_byteen,
   input lsu_data_t    fwd_data,
   input logic         stbuf_empty,
   input logic         stbuf_full
);

   typedef struct packed {
      word_addr_t word;
      byte_en_t   be;
      lsu_data_t  data;
   } ref_entry_t;

   ref_entry_t model[$];      // oldest entry at the front
   byte_en_t   exp_fwd_be = '0;
   lsu_data_t  exp_fwd_data = '0;
   logic       fwd_seen = 1'b0;  // fwd_data has no reset value
   string      test_name = "startup";
   int         tests = 0;
   int         checks = 0;
   int         errors = 0;
   int         test_errs = 0;

   function automatic word_addr_t word_of(lsu_addr_t a);
      return a[`STBUF_ADDR_BITS-1:2];
   endfunction

   // reference: place the store's bytes into an entry, other bytes unchanged
   function automatic ref_entry_t merge_store(ref_entry_t old, access_size_e size,
                                              lsu_addr_t addr, lsu_data_t d);
      ref_entry_t r;
      int         off;
      int         n;
      r = old;
      off = int'(addr[1:0]);
      case (size)
         size_byte: n = 1;
         size_half: n = 2;
         default:   n = 4;
      endcase
      for (int j = 0; j < `STBUF_BYTE_WIDTH; j++) begin
         if (j >= off && j < off + n) begin
            r.be[j] = 1'b1;
            r.data[8*j +: 8] = d[8*(j-off) +: 8];  // store data is right aligned
         end
      end
      return r;
   endfunction

   // --------------------
   // model update
   // --------------------
   always @(posedge clk) begin
      int idx;
      if (!arst_n) begin
         model.delete();
         exp_fwd_be = '0;
         fwd_seen = 1'b0;
      end else begin
         if (ld_cmpen) begin  // lookup sees the state before this edge
            exp_fwd_be = '0;
            exp_fwd_data = '0;
            fwd_seen = 1'b1;
            foreach (model[i]) begin
               if (model[i].word == word_of(ld_addr)) begin
                  exp_fwd_be = exp_fwd_be | model[i].be;
                  exp_fwd_data = exp_fwd_data | model[i].data;
               end
            end
         end
         if (stbuf_commit && model.size() != 0) model.delete(0);  // pop before the store
         if (st_vld) begin
            idx = -1;
            foreach (model[i]) begin
               if (model[i].word == word_of(st_addr)) idx = i;
            end
            if (idx >= 0) model[idx] = merge_store(model[idx], st_size, st_addr, st_data);
            else model.push_back(merge_store('{word_of(st_addr), '0, '0},
                                             st_size, st_addr, st_data));
         end
      end
   end

   // --------------------
   // comparison
   // --------------------
   task automatic check_value(string what, logic [31:0] exp, logic [31:0] act);
      checks++;
      if (act !== exp) begin
         errors++;
         test_errs++;
         $display("Fail %s %s: expected %h, actual %h", test_name, what, exp, act);
      end
   endtask

   // outputs settle between edges, so compare on the falling edge
   always @(negedge clk) begin
      check_value("stbuf_empty", 32'(model.size() == 0), 32'(stbuf_empty));
      check_value("stbuf_full", 32'(model.size() == `STBUF_DEPTH), 32'(stbuf_full));
      check_value("stbuf_reqvld", 32'(model.size() != 0), 32'(stbuf_reqvld));
      if (model.size() != 0) begin
         check_value("stbuf_addr", 32'(model[0].word), 32'(stbuf_addr));
         check_value("stbuf_data", model[0].data, stbuf_data);
      end
      check_value("fwd_byteen", 32'(exp_fwd_be), 32'(fwd_byteen));
      if (fwd_seen) check_value("fwd_data", exp_fwd_data, fwd_data);
   end

   // --------------------
   // reporting
   // --------------------
   task automatic begin_test(string name);
      test_name = name;
   endtask

   task automatic end_test();
      tests++;
      if (test_errs == 0) $display("%s: pass", test_name);
      else $display("%s: %0d errors", test_name, test_errs);
      test_errs = 0;
   endtask

   task automatic report_counts(int assert_fails);
      $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
               tests, checks, errors, assert_fails);
   endtask

endmodule

`default_nettype wire

/* testbench/stbuf_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_checker (
   input logic clk,
   input logic arst_n,
   input logic st_vld,
   input logic new_entry,
   input logic stbuf_commit,
   input logic stbuf_reqvld,
   input logic stbuf_empty,
   input logic stbuf_full
);

   int fails = 0;  // read by the testbench at the end of the run

   // --------------------
   // caller rules
   // --------------------
   a_no_alloc_when_full: assert property (@(posedge clk) disable iff (!arst_n)
      (st_vld && stbuf_full) |-> !new_entry)
      else begin
         $error("store into a full buffer did not coalesce");
         fails++;
      end

   a_commit_needs_head: assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_commit |-> stbuf_reqvld)
      else begin
         $error("commit while no entry is offered");
         fails++;
      end

   // --------------------
   // flag consistency
   // --------------------
   // the head is offered exactly when the buffer holds something
   a_empty_vs_reqvld: assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_reqvld == !stbuf_empty)
      else begin
         $error("reqvld does not follow the empty flag");
         fails++;
      end

   a_empty_vs_full: assert property (@(posedge clk) disable iff (!arst_n)
      !(stbuf_empty && stbuf_full))
      else begin
         $error("empty and full high together");
         fails++;
      end

endmodule

bind stbuf_top stbuf_checker chk (
   .clk          (clk),
   .arst_n       (arst_n),
   .st_vld       (st_vld),
   .new_entry    (new_entry),
   .stbuf_commit (stbuf_commit),
   .stbuf_reqvld (stbuf_reqvld),
   .stbuf_empty  (stbuf_empty),
   .stbuf_full   (stbuf_full)
);

`default_nettype wire

/* rtl/stbuf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module stbuf_top
   import lsu_types_pkg::*, stbuf_pkg::*;
(
   input  logic         clk,
   input  logic         arst_n,
   // store side
   input  logic         st_vld,
   input  lsu_addr_t    st_addr,
   input  access_size_e st_size,
   input  lsu_data_t    st_data,
   // drain side
   input  logic         stbuf_commit,
   output logic         stbuf_reqvld,
   output word_addr_t   stbuf_addr,
   output lsu_data_t    stbuf_data,
   // load compare
   input  logic         ld_cmpen,
   input  lsu_addr_t    ld_addr,
   output byte_en_t     fwd_byteen,
   output lsu_data_t    fwd_data,
   // occupancy
   output logic         stbuf_empty,
   output logic         stbuf_full
);

   stbuf_vec_t wr_en;
   logic       new_entry;

   stbuf_entry_if entry_if ();

   stbuf_alloc u_alloc (
      .clk       (clk),
      .arst_n    (arst_n),
      .st_vld    (st_vld),
      .st_addr   (st_addr),
      .entries   (entry_if),
      .wr_en     (wr_en),
      .new_entry (new_entry)
   );

   stbuf_array u_array (
      .clk          (clk),
      .arst_n       (arst_n),
      .st_addr      (st_addr),
      .st_size      (st_size),
      .st_data      (st_data),
      .wr_en        (wr_en),
      .new_entry    (new_entry),
      .stbuf_commit (stbuf_commit),
      .entries      (entry_if),
      .stbuf_reqvld (stbuf_reqvld),
      .stbuf_addr   (stbuf_addr),
      .stbuf_data   (stbuf_data),
      .stbuf_empty  (stbuf_empty),
      .stbuf_full   (stbuf_full)
   );

   stbuf_fwd u_fwd (
      .clk        (clk),
      .arst_n     (arst_n),
      .ld_cmpen   (ld_cmpen),
      .ld_addr    (ld_addr),
      .entries    (entry_if),
      .fwd_byteen (fwd_byteen),
      .fwd_data   (fwd_data)
   );

endmodule

`default_nettype wire

/* rtl/stbuf_fwd.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stbuf_defines.svh"

module stbuf_fwd
   import lsu_types_pkg::*, stbuf_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  ld_cmpen,
   input  lsu_addr_t             ld_addr,
   stbuf_entry_if.reader         entries,
   output byte_en_t              fwd_byteen,
   output lsu_data_t             fwd_data
);

   word_addr_t ld_word;
   stbuf_vec_t match;
   byte_en_t   hit_byteen;
   lsu_data_t  hit_data;

   assign ld_word = to_word_addr(ld_addr);

   // --------------------
   // load lookup
   // --------------------
   always_comb begin
      hit_byteen = '0;
      hit_data   = '0;
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         match[i] = entries.vld[i] & (entries.addr[i] == ld_word);
         if (match[i]) begin
            hit_byteen = hit_byteen | entries.byteen[i];
            hit_data   = hit_data | entries.data[i];    // at most one live entry per word
         end
      end
   end

   // --------------------
   // result registers
   // --------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         fwd_byteen <= '0;
      end else if (ld_cmpen) begin
         fwd_byteen <= hit_byteen;  // zero on a miss
      end
   end

   // held until the next compare
   always_ff @(posedge clk) begin
      if (ld_cmpen) begin
         fwd_data <= hit_data;
      end
   end

endmodule

`default_nettype wire

/* rtl/stbuf_array.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stbuf_defines.svh"

module stbuf_array
   import lsu_types_pkg::*, stbuf_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  lsu_addr_t             st_addr,
   input  access_size_e          st_size,
   input  lsu_data_t             st_data,
   input  stbuf_vec_t            wr_en,
   input  logic                  new_entry,
   input  logic                  stbuf_commit,
   stbuf_entry_if.owner          entries,
   output logic                  stbuf_reqvld,
   output word_addr_t            stbuf_addr,
   output lsu_data_t             stbuf_data,
   output logic                  stbuf_empty,
   output logic                  stbuf_full
);

   logic [$clog2(`STBUF_BYTE_WIDTH)-1:0] st_off;
   byte_en_t     size_mask;
   byte_en_t     st_be;
   lsu_data_t    st_lane;
   stbuf_ptr_t   rd_ptr;
   stbuf_count_t vld_cnt;
   logic         pop;

   // --------------------
   // store byte lanes
   // --------------------
   assign st_off = st_addr[$clog2(`STBUF_BYTE_WIDTH)-1:0];

   always_comb begin
      case (st_size)
         size_byte: size_mask = byte_en_t'(4'b0001);
         size_half: size_mask = byte_en_t'(4'b0011);
         default:   size_mask = '1;
      endcase
   end

   assign st_be   = size_mask << st_off;
   assign st_lane = st_data << {st_off, 3'b000};  // store data arrives right aligned

   // --------------------
   // head and pop
   // --------------------
   assign pop          = stbuf_commit & stbuf_reqvld;
   assign entries.clr  = pop ? (stbuf_vec_t'(1) << rd_ptr) : '0;
   assign stbuf_reqvld = entries.vld[rd_ptr];
   assign stbuf_addr   = entries.addr[rd_ptr];
   assign stbuf_data   = entries.data[rd_ptr];

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         entries.vld <= '0;
         rd_ptr      <= '0;
      end else begin
         entries.vld <= (entries.vld & ~entries.clr) | wr_en;  // a write wins over the pop
         if (pop) rd_ptr <= ptr_inc(rd_ptr);
      end
   end

   // entry payload, merged byte by byte
   always_ff @(posedge clk) begin
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         if (wr_en[i]) begin
            entries.addr[i]   <= to_word_addr(st_addr);
            entries.byteen[i] <= (new_entry ? '0 : entries.byteen[i]) | st_be;
            for (int j = 0; j < `STBUF_BYTE_WIDTH; j++) begin
               if (st_be[j]) entries.data[i][8*j +: 8] <= st_lane[8*j +: 8];
               else if (new_entry) entries.data[i][8*j +: 8] <= '0;  // unwritten lanes read as 0
            end
         end
      end
   end

   // --------------------
   // occupancy
   // --------------------
   always_comb begin
      vld_cnt = '0;
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         vld_cnt = vld_cnt + stbuf_count_t'(entries.vld[i]);
      end
   end

   assign stbuf_empty = (vld_cnt == '0);
   assign stbuf_full  = (vld_cnt == stbuf_count_t'(`STBUF_DEPTH));

endmodule

`default_nettype wire

/* rtl/stbuf_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stbuf_defines.svh"

module stbuf_alloc
   import lsu_types_pkg::*, stbuf_pkg::*;
(
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  st_vld,
   input  lsu_addr_t             st_addr,
   stbuf_entry_if.reader         entries,
   output stbuf_vec_t            wr_en,
   output logic                  new_entry
);

   stbuf_ptr_t wr_ptr;
   stbuf_vec_t match;
   stbuf_vec_t wr_onehot;
   word_addr_t st_word;
   logic       coalesce;

   assign st_word = to_word_addr(st_addr);

   // --------------------
   // coalesce lookup
   // --------------------
   always_comb begin
      for (int i = 0; i < `STBUF_DEPTH; i++) begin
         // an entry on its way out cannot take more bytes
         match[i] = entries.vld[i] & ~entries.clr[i] & (entries.addr[i] == st_word);
      end
   end

   assign coalesce  = |match;
   assign new_entry = st_vld & ~coalesce;
   assign wr_onehot = stbuf_vec_t'(1) << wr_ptr;

   always_comb begin
      if (!st_vld) wr_en = '0;
      else if (coalesce) wr_en = match;     // merge into the hit
      else wr_en = wr_onehot;               // allocate at the tail
   end

   // --------------------
   // write pointer
   // --------------------
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
      end else if (new_entry) begin
         wr_ptr <= ptr_inc(wr_ptr);
      end
   end

endmodule

`default_nettype wire

/* rtl/stbuf_entry_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "stbuf_defines.svh"

interface stbuf_entry_if
   import lsu_types_pkg::*, stbuf_pkg::*;
   ();

   stbuf_vec_t vld;                          // entry holds a store
   word_addr_t addr   [`STBUF_DEPTH];
   byte_en_t   byteen [`STBUF_DEPTH];
   lsu_data_t  data   [`STBUF_DEPTH];
   stbuf_vec_t clr;                          // head entry being popped this cycle

   modport owner  (output vld, addr, byteen, data, clr);
   modport reader (input  vld, addr, byteen, data, clr);

endinterface

`default_nettype wire

/* rtl/stbuf_pkg.sv */
`default_nettype none

`include "stbuf_defines.svh"

package stbuf_pkg;

   typedef logic [$clog2(`STBUF_DEPTH)-1:0]   stbuf_ptr_t;    // entry index
   typedef logic [`STBUF_DEPTH-1:0]           stbuf_vec_t;    // one bit per entry
   typedef logic [$clog2(`STBUF_DEPTH+1)-1:0] stbuf_count_t;  // 0 .. depth

   // circular pointer step, wraps at the last entry
   function automatic stbuf_ptr_t ptr_inc(stbuf_ptr_t p);
      return (p == stbuf_ptr_t'(`STBUF_DEPTH - 1)) ? '0 : p + 1'b1;
   endfunction

endpackage

`default_nettype wire

/* rtl/lsu_types_pkg.sv */
`default_nettype none

`include "stbuf_defines.svh"

package lsu_types_pkg;

   // access width of a load or store
   typedef enum logic [1:0] {
      size_byte = 2'd0,
      size_half = 2'd1,
      size_word = 2'd2
   } access_size_e;

   typedef logic [`STBUF_ADDR_BITS-1:0]                               lsu_addr_t;
   typedef logic [`STBUF_ADDR_BITS-$clog2(`STBUF_BYTE_WIDTH)-1:0]     word_addr_t;
   typedef logic [`STBUF_BYTE_WIDTH-1:0]                              byte_en_t;
   typedef logic [`STBUF_DATA_WIDTH-1:0]                              lsu_data_t;

   // drop the byte offset
   function automatic word_addr_t to_word_addr(lsu_addr_t a);
      return a[`STBUF_ADDR_BITS-1:$clog2(`STBUF_BYTE_WIDTH)];
   endfunction

endpackage

`default_nettype wire

/* rtl/stbuf_defines.svh */
`ifndef STBUF_DEFINES_SVH
`define STBUF_DEFINES_SVH

// --------------------
// store buffer sizing
// --------------------
`define STBUF_DEPTH      4   // entries
`define STBUF_ADDR_BITS  16  // byte address kept per entry
`define STBUF_DATA_WIDTH 32
`define STBUF_BYTE_WIDTH 4   // byte lanes per entry

`endif
